// ==== verilog/mpmc_consts.svh ====
`ifndef MPMC_CONSTS_SVH
`define MPMC_CONSTS_SVH

// ==============================
// channel side
// ==============================
`define MPMC_NCH        4
`define MPMC_AW         32
`define MPMC_DW         128
// one select bit per byte lane
`define MPMC_SW         16

// ==============================
// application port
// ==============================
// channel address bits 31..3 with the line offset bit forced low
`define MPMC_APP_AW     29
`define MPMC_FIFO_DEPTH 8
`define MPMC_CMD_WRITE  3'd0
`define MPMC_CMD_READ   3'd1

`endif

// ==== verilog/mpmc_pkg.sv ====
`default_nettype none

`include "mpmc_consts.svh"

package mpmc_pkg;

	// controller sequencing
	typedef enum logic [2:0]
	{
		IDLE,
		PRESET,
		WRITE_CMD,
		WRITE_DATA,
		READ_CMD,
		READ_WAIT
	} mpmc_state_t;

	// index of a requesting channel
	typedef logic [1:0] mpmc_ch_t;

	// one queued line request of 179 bits
	typedef struct packed
	{
		mpmc_ch_t                ch;
		logic                    we;
		logic [`MPMC_AW-1:0]     adr;
		logic [`MPMC_SW-1:0]     sel;
		logic [`MPMC_DW-1:0]     dat;
	} mpmc_req_t;

endpackage

`default_nettype wire

// ==== verilog/mpmc_req_arbiter.sv ====
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_req_arbiter
	import mpmc_pkg::*;
(
	input  wire                                    mem_ui_clk,
	input  wire                                    rst,
	input  wire [`MPMC_NCH-1:0]                    ch_stb,
	input  wire [`MPMC_NCH-1:0]                    ch_we,
	input  wire [`MPMC_NCH-1:0][`MPMC_AW-1:0]      ch_adr,
	input  wire [`MPMC_NCH-1:0][`MPMC_SW-1:0]      ch_sel,
	input  wire [`MPMC_NCH-1:0][`MPMC_DW-1:0]      ch_dat,
	input  wire                                    fifo_full,
	input  wire [`MPMC_NCH-1:0]                    ack_done,
	output logic                                   push,
	output mpmc_req_t                              push_req
);

	logic [`MPMC_NCH-1:0] stb_r;
	logic [`MPMC_NCH-1:0] stb_d;
	logic [`MPMC_NCH-1:0] we_r;
	logic [`MPMC_NCH-1:0][`MPMC_AW-1:0] adr_r;
	logic [`MPMC_NCH-1:0][`MPMC_SW-1:0] sel_r;
	logic [`MPMC_NCH-1:0][`MPMC_DW-1:0] dat_r;
	logic [`MPMC_NCH-1:0] rise;
	logic [`MPMC_NCH-1:0] pending;
	logic [`MPMC_NCH-1:0] queued;
	logic [`MPMC_NCH-1:0] elig;
	mpmc_ch_t last;
	mpmc_ch_t grant;
	mpmc_ch_t idx;
	logic found;

	// ==============================
	// input register and edge detect
	// ==============================
	always_ff @(posedge mem_ui_clk)
	if (rst)
	begin
		stb_r <= '0;
		stb_d <= '0;
	end
	else
	begin
		stb_r <= ch_stb;
		stb_d <= stb_r;
	end

	always_ff @(posedge mem_ui_clk)
	begin
		we_r  <= ch_we;
		adr_r <= ch_adr;
		sel_r <= ch_sel;
		dat_r <= ch_dat;
	end

	assign rise = stb_r & ~stb_d;
	// pending but not yet in the request FIFO
	assign elig = pending & ~queued;

	// ==============================
	// round robin search from the channel after the last winner
	// ==============================
	always_comb
	begin
		grant = last;
		found = 1'b0;
		idx = last;
		for (int i = 1; i <= `MPMC_NCH; i++)
		begin
			idx = last + mpmc_ch_t'(i);
			if (!found && elig[idx])
			begin
				grant = idx;
				found = 1'b1;
			end
		end
	end

	assign push = found & ~fifo_full;

	always_comb
	begin
		push_req.ch  = grant;
		push_req.we  = we_r[grant];
		push_req.adr = adr_r[grant];
		push_req.sel = sel_r[grant];
		push_req.dat = dat_r[grant];
	end

	always_ff @(posedge mem_ui_clk)
	if (rst)
	begin
		pending <= '0;
		queued  <= '0;
		last    <= mpmc_ch_t'(`MPMC_NCH - 1);
	end
	else
	begin
		pending <= (pending | rise) & ~ack_done;
		queued  <= queued & ~ack_done;
		if (push)
		begin
			queued[grant] <= 1'b1;
			last <= grant;
		end
	end

	// a channel keeps one request outstanding until its ack
	a_no_double_pend: assert property (@(posedge mem_ui_clk) disable iff (rst)
		(rise & pending) == '0)
		else $error("new strobe on a channel that is still pending");

endmodule

`default_nettype wire

// ==== verilog/mpmc_req_fifo.sv ====
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_req_fifo
	import mpmc_pkg::*;
(
	input  wire             mem_ui_clk,
	input  wire             rst,
	input  wire             push,
	input  wire mpmc_req_t  push_req,
	input  wire             pop,
	output mpmc_req_t       head,
	output logic            empty,
	output logic            full
);

	localparam int PW = $clog2(`MPMC_FIFO_DEPTH);

	mpmc_req_t mem [`MPMC_FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0] count;

	always_ff @(posedge mem_ui_clk)
		if (push)
			mem[wr_ptr] <= push_req;

	// pointers wrap naturally since the depth is a power of two
	always_ff @(posedge mem_ui_clk)
	if (rst)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end
	else
	begin
		if (push)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
		case ({push, pop})
		2'b10:   count <= count + 1'b1;
		2'b01:   count <= count - 1'b1;
		default: count <= count;
		endcase
	end

	// first word fall through
	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == (PW+1)'(`MPMC_FIFO_DEPTH));

	a_no_overflow: assert property (@(posedge mem_ui_clk) disable iff (rst) !(push && full))
		else $error("request FIFO push while full");
	a_no_underflow: assert property (@(posedge mem_ui_clk) disable iff (rst) !(pop && empty))
		else $error("request FIFO pop while empty");

endmodule

`default_nettype wire

// ==== verilog/mpmc_state_machine.sv ====
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_state_machine
	import mpmc_pkg::*;
(
	input  wire                        mem_ui_clk,
	input  wire                        rst,
	input  wire mpmc_req_t             head,
	input  wire                        empty,
	input  wire                        app_rdy,
	input  wire                        app_wdf_rdy,
	input  wire                        app_rd_data_valid,
	output logic                       pop,
	output logic                       app_en,
	output logic [2:0]                 app_cmd,
	output logic [`MPMC_APP_AW-1:0]    app_addr,
	output logic                       app_wdf_wren,
	output logic                       app_wdf_end,
	output logic [`MPMC_DW-1:0]        app_wdf_data,
	output logic [`MPMC_SW-1:0]        app_wdf_mask,
	output logic                       wr_done,
	output mpmc_ch_t                   cur_ch
);

	mpmc_state_t state;
	logic [`MPMC_DW-1:0] fill_data;

	// unselected byte lanes go out as all ones
	always_comb
	begin
		for (int g = 0; g < `MPMC_SW; g++)
			fill_data[g*8 +: 8] = head.sel[g] ? head.dat[g*8 +: 8] : 8'hFF;
	end

	// head is consumed in the cycle it is latched
	assign pop = (state == PRESET);

	// ==============================
	// sequencing
	// ==============================
	always_ff @(posedge mem_ui_clk)
	if (rst)
	begin
		state        <= IDLE;
		app_en       <= 1'b0;
		app_wdf_wren <= 1'b0;
		app_wdf_end  <= 1'b0;
		wr_done      <= 1'b0;
		cur_ch       <= '0;
	end
	else
	begin
		wr_done <= 1'b0;
		case (state)
		IDLE:
			if (!empty)
				state <= PRESET;
		PRESET:
		begin
			cur_ch <= head.ch;
			app_en <= 1'b1;
			state  <= head.we ? WRITE_CMD : READ_CMD;
		end
		// command held until the port takes it
		WRITE_CMD:
			if (app_rdy)
			begin
				app_en       <= 1'b0;
				app_wdf_wren <= 1'b1;
				app_wdf_end  <= 1'b1;
				state        <= WRITE_DATA;
			end
		// end follows wren on a single beat
		WRITE_DATA:
			if (app_wdf_rdy)
			begin
				app_wdf_wren <= 1'b0;
				app_wdf_end  <= 1'b0;
				wr_done      <= 1'b1;
				state        <= IDLE;
			end
		READ_CMD:
			if (app_rdy)
			begin
				app_en <= 1'b0;
				state  <= READ_WAIT;
			end
		READ_WAIT:
			if (app_rd_data_valid)
				state <= IDLE;
		default:
			state <= IDLE;
		endcase
	end

	// ==============================
	// command and write payload
	// ==============================
	always_ff @(posedge mem_ui_clk)
		if (state == PRESET)
		begin
			app_cmd      <= head.we ? `MPMC_CMD_WRITE : `MPMC_CMD_READ;
			app_addr     <= {head.adr[`MPMC_AW-1:4], 1'b0};
			app_wdf_data <= fill_data;
			app_wdf_mask <= ~head.sel;
		end

	// data phase only starts once the command has been taken
	a_cmd_data_apart: assert property (@(posedge mem_ui_clk) disable iff (rst)
		!(app_en && app_wdf_wren))
		else $error("app_en and app_wdf_wren high together");

endmodule

`default_nettype wire

// ==== verilog/mpmc_resp_route.sv ====
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_resp_route
	import mpmc_pkg::*;
(
	input  wire                                    mem_ui_clk,
	input  wire                                    rst,
	input  wire                                    app_rd_data_valid,
	input  wire [`MPMC_DW-1:0]                     app_rd_data,
	input  wire                                    wr_done,
	input  wire mpmc_ch_t                          cur_ch,
	output logic [`MPMC_NCH-1:0]                   ch_ack,
	output logic [`MPMC_NCH-1:0][`MPMC_DW-1:0]     ch_dat_o,
	output logic [`MPMC_NCH-1:0]                   ack_done
);

	logic rd_valid_r;
	logic [`MPMC_DW-1:0] rd_data_r;
	logic ack_any;

	always_ff @(posedge mem_ui_clk)
	if (rst)
		rd_valid_r <= 1'b0;
	else
		rd_valid_r <= app_rd_data_valid;

	always_ff @(posedge mem_ui_clk)
		if (app_rd_data_valid)
			rd_data_r <= app_rd_data;

	// write done and read return never overlap with one request in flight
	assign ack_any = wr_done | rd_valid_r;

	// ==============================
	// per channel decode
	// ==============================
	always_comb
	begin
		for (int n = 0; n < `MPMC_NCH; n++)
		begin
			ch_ack[n]   = ack_any && (cur_ch == mpmc_ch_t'(n));
			ch_dat_o[n] = (cur_ch == mpmc_ch_t'(n)) ? rd_data_r : '0;
		end
	end

	// clears pending in the arbiter
	assign ack_done = ch_ack;

	a_one_ack: assert property (@(posedge mem_ui_clk) disable iff (rst)
		!(wr_done && rd_valid_r))
		else $error("write and read acknowledge in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/mpmc_top.sv ====
`default_nettype none

`include "mpmc_consts.svh"

module mpmc_top
	import mpmc_pkg::*;
(
	input  wire                                    mem_ui_clk,
	input  wire                                    rst,
	// channel bus
	input  wire [`MPMC_NCH-1:0]                    ch_stb,
	input  wire [`MPMC_NCH-1:0]                    ch_we,
	input  wire [`MPMC_NCH-1:0][`MPMC_AW-1:0]      ch_adr,
	input  wire [`MPMC_NCH-1:0][`MPMC_SW-1:0]      ch_sel,
	input  wire [`MPMC_NCH-1:0][`MPMC_DW-1:0]      ch_dat,
	output logic [`MPMC_NCH-1:0]                   ch_ack,
	output logic [`MPMC_NCH-1:0][`MPMC_DW-1:0]     ch_dat_o,
	// memory application port
	input  wire                                    app_rdy,
	output logic                                   app_en,
	output logic [2:0]                             app_cmd,
	output logic [`MPMC_APP_AW-1:0]                app_addr,
	input  wire                                    app_wdf_rdy,
	output logic                                   app_wdf_wren,
	output logic                                   app_wdf_end,
	output logic [`MPMC_DW-1:0]                    app_wdf_data,
	output logic [`MPMC_SW-1:0]                    app_wdf_mask,
	input  wire                                    app_rd_data_valid,
	input  wire [`MPMC_DW-1:0]                     app_rd_data
);

	logic push;
	mpmc_req_t push_req;
	mpmc_req_t head;
	logic empty;
	logic full;
	logic pop;
	logic wr_done;
	mpmc_ch_t cur_ch;
	logic [`MPMC_NCH-1:0] ack_done;

	mpmc_req_arbiter u_arb (
		.mem_ui_clk (mem_ui_clk),
		.rst        (rst),
		.ch_stb     (ch_stb),
		.ch_we      (ch_we),
		.ch_adr     (ch_adr),
		.ch_sel     (ch_sel),
		.ch_dat     (ch_dat),
		.fifo_full  (full),
		.ack_done   (ack_done),
		.push       (push),
		.push_req   (push_req)
	);

	mpmc_req_fifo u_fifo (
		.mem_ui_clk (mem_ui_clk),
		.rst        (rst),
		.push       (push),
		.push_req   (push_req),
		.pop        (pop),
		.head       (head),
		.empty      (empty),
		.full       (full)
	);

	mpmc_state_machine u_sm (
		.mem_ui_clk        (mem_ui_clk),
		.rst               (rst),
		.head              (head),
		.empty             (empty),
		.app_rdy           (app_rdy),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.pop               (pop),
		.app_en            (app_en),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask      (app_wdf_mask),
		.wr_done           (wr_done),
		.cur_ch            (cur_ch)
	);

	mpmc_resp_route u_route (
		.mem_ui_clk        (mem_ui_clk),
		.rst               (rst),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.wr_done           (wr_done),
		.cur_ch            (cur_ch),
		.ch_ack            (ch_ack),
		.ch_dat_o          (ch_dat_o),
		.ack_done          (ack_done)
	);

endmodule

`default_nettype wire

// ==== testbench/app_mem_model.sv ====
`default_nettype none

`include "mpmc_consts.svh"

module app_mem_model #(
	parameter int SEED = 1
)
(
	input  wire                       mem_ui_clk,
	input  wire                       app_en,
	input  wire [2:0]                 app_cmd,
	input  wire [`MPMC_APP_AW-1:0]    app_addr,
	output logic                      app_rdy,
	input  wire                       app_wdf_wren,
	input  wire                       app_wdf_end,
	input  wire [`MPMC_DW-1:0]        app_wdf_data,
	input  wire [`MPMC_SW-1:0]        app_wdf_mask,
	output logic                      app_wdf_rdy,
	output logic                      app_rd_data_valid,
	output logic [`MPMC_DW-1:0]       app_rd_data,
	output int                        errors
);

	logic [`MPMC_DW-1:0] lines [64];
	logic [`MPMC_DW-1:0] rd_buf [3];
	logic [2:0] rd_pipe;
	logic wr_pending;
	logic [5:0] wr_line;
	logic take_cmd;
	logic take_data;
	int seed;
	int rnd;

	initial
	begin
		seed = SEED;
		errors = 0;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
		rd_pipe = '0;
		wr_pending = 1'b0;
		wr_line = '0;
		// every 32 bit word tagged with its line and word index
		for (int i = 0; i < 64; i++)
			for (int w = 0; w < 4; w++)
				lines[i][w*32 +: 32] = {8'h5A, 2'b00, 6'(i), 8'hC3, 6'b0, 2'(w)};
	end

	always @(posedge mem_ui_clk)
	begin
		// handshakes as the DUT sees them at this edge
		take_cmd = app_en && app_rdy;
		take_data = app_wdf_wren && app_wdf_rdy;
		if (take_data)
		begin
			if (!wr_pending || !app_wdf_end)
			begin
				errors++;
				$display("memory model got write data without a write command or end flag");
			end
			for (int b = 0; b < `MPMC_SW; b++)
			begin
				if (!app_wdf_mask[b])
					lines[wr_line][b*8 +: 8] = app_wdf_data[b*8 +: 8];
				else if (app_wdf_data[b*8 +: 8] !== 8'hFF)
				begin
					errors++;
					$display("Error at time %0t: app_wdf_data byte %0d = %h, expected ff",
						$time, b, app_wdf_data[b*8 +: 8]);
				end
			end
			wr_pending = 1'b0;
		end
		rd_pipe = {rd_pipe[1:0], 1'b0};
		rd_buf[2] = rd_buf[1];
		rd_buf[1] = rd_buf[0];
		if (take_cmd)
		begin
			// line index sits above the forced-low address bit
			if (app_cmd == `MPMC_CMD_WRITE)
			begin
				wr_pending = 1'b1;
				wr_line = app_addr[6:1];
			end
			else if (app_cmd == `MPMC_CMD_READ)
			begin
				rd_pipe[0] = 1'b1;
				rd_buf[0] = lines[app_addr[6:1]];
			end
			else
			begin
				errors++;
				$display("Error at time %0t: app_cmd = %0d, expected 0 or 1", $time, app_cmd);
			end
		end
		rnd = $random(seed);
		#1;
		app_rdy = (rnd[1:0] != 2'b00);
		app_wdf_rdy = (rnd[3:2] != 2'b00);
		app_rd_data_valid = rd_pipe[2];
		if (rd_pipe[2])
			app_rd_data = rd_buf[2];
	end

endmodule

`default_nettype wire

// ==== testbench/tb_mpmc.sv ====
`default_nettype none

`include "mpmc_consts.svh"

module tb_mpmc;

	localparam int N_TESTS = 23;
	localparam int N_COLS = 7;
	localparam int RAND_SEED = 35;
	// per request line plus reset and idle check
	localparam int CYCLE_LIMIT = 200 * N_TESTS + 50;
	localparam int C_GROUP = 0;
	localparam int C_CH = 1;
	localparam int C_WE = 2;
	localparam int C_ADR = 3;
	localparam int C_SEL = 4;
	localparam int C_DAT = 5;
	localparam int C_EXP = 6;

	logic mem_ui_clk;
	logic rst;
	logic [`MPMC_NCH-1:0] ch_stb;
	logic [`MPMC_NCH-1:0] ch_we;
	logic [`MPMC_NCH-1:0][`MPMC_AW-1:0] ch_adr;
	logic [`MPMC_NCH-1:0][`MPMC_SW-1:0] ch_sel;
	logic [`MPMC_NCH-1:0][`MPMC_DW-1:0] ch_dat;
	logic [`MPMC_NCH-1:0] ch_ack;
	logic [`MPMC_NCH-1:0][`MPMC_DW-1:0] ch_dat_o;
	logic app_rdy;
	logic app_en;
	logic [2:0] app_cmd;
	logic [`MPMC_APP_AW-1:0] app_addr;
	logic app_wdf_rdy;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic [`MPMC_DW-1:0] app_wdf_data;
	logic [`MPMC_SW-1:0] app_wdf_mask;
	logic app_rd_data_valid;
	logic [`MPMC_DW-1:0] app_rd_data;

	logic [`MPMC_DW-1:0] td [N_TESTS*N_COLS];
	logic [`MPMC_NCH-1:0] in_flight;
	logic timed_out;
	int model_errors;
	int errors;
	int checks;
	int cycles;
	int first;
	int last;

	mpmc_top DUT (.*);

	app_mem_model #(.SEED(RAND_SEED)) mem_model (.*, .errors(model_errors));

	initial
	begin
		mem_ui_clk = 1'b0;
		forever #20 mem_ui_clk = ~mem_ui_clk;
	end

	// ==============================
	// one channel of a group
	// ==============================
	task automatic serve_channel(input int n, input int lo, input int hi);
		int row;
		begin
			for (int t = lo; t <= hi; t++)
			begin
				row = t * N_COLS;
				if (td[row + C_CH] == n)
				begin
					ch_we[n] = td[row + C_WE][0];
					ch_adr[n] = td[row + C_ADR][`MPMC_AW-1:0];
					ch_sel[n] = td[row + C_SEL][`MPMC_SW-1:0];
					ch_dat[n] = td[row + C_DAT];
					ch_stb[n] = 1'b1;
					in_flight[n] = 1'b1;
					// strobe held until the ack pulse
					do
					begin
						@(posedge mem_ui_clk);
						#1;
					end
					while (ch_ack[n] !== 1'b1);
					checks++;
					if (!ch_we[n] && ch_dat_o[n] !== td[row + C_EXP])
					begin
						errors++;
						$display("Error at time %0t: ch_dat_o[%0d] = %h, expected %h",
							$time, n, ch_dat_o[n], td[row + C_EXP]);
					end
					@(posedge mem_ui_clk);
					#1;
					ch_stb[n] = 1'b0;
					in_flight[n] = 1'b0;
					@(posedge mem_ui_clk);
					#1;
				end
			end
		end
	endtask

	task automatic finish_run;
		begin
			$display("acks %0d of %0d, errors %0d, memory model errors %0d, timeout %0d",
				checks, N_TESTS, errors, model_errors, timed_out);
			if (errors == 0 && model_errors == 0 && !timed_out && checks == N_TESTS)
				$display("Test completed successfully");
			else
				$display("Test failed");
			$finish;
		end
	endtask

	// an ack must belong to a strobe that is still up
	always @(posedge mem_ui_clk)
		if (!rst && (ch_ack & ~in_flight) != '0)
		begin
			errors++;
			$display("Error at time %0t: ch_ack = %b, expected only bits of %b",
				$time, ch_ack, in_flight);
		end

	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge mem_ui_clk);
			cycles++;
		end
		timed_out = 1'b1;
		$display("run stopped after %0d cycles before all requests were acknowledged", cycles);
		finish_run;
	end

	// ==============================
	// main sequence
	// ==============================
	initial
	begin
		rst = 1'b1;
		ch_stb = '0;
		ch_we = '0;
		ch_adr = '0;
		ch_sel = '0;
		ch_dat = '0;
		in_flight = '0;
		timed_out = 1'b0;
		errors = 0;
		checks = 0;
		$readmemh("testbench/mpmc_testdata.txt", td);
		repeat (2) @(posedge mem_ui_clk);
		#1;
		rst = 1'b0;
		// nothing moves without a strobe
		repeat (8)
		begin
			@(posedge mem_ui_clk);
			#1;
			if (ch_ack !== '0)
			begin
				errors++;
				$display("Error at time %0t: ch_ack = %b, expected 0", $time, ch_ack);
			end
			if (app_en !== 1'b0 || app_wdf_wren !== 1'b0)
			begin
				errors++;
				$display("Error at time %0t: app_en = %b, app_wdf_wren = %b, expected 0 and 0",
					$time, app_en, app_wdf_wren);
			end
		end
		first = 0;
		while (first < N_TESTS)
		begin
			last = first;
			while (last + 1 < N_TESTS &&
				td[(last + 1) * N_COLS + C_GROUP] == td[first * N_COLS + C_GROUP])
				last++;
			fork
				serve_channel(0, first, last);
				serve_channel(1, first, last);
				serve_channel(2, first, last);
				serve_channel(3, first, last);
			join
			first = last + 1;
		end
		repeat (4) @(posedge mem_ui_clk);
		finish_run;
	end

endmodule

`default_nettype wire

// ==== testbench/mpmc_testdata.txt ====
// group channel write address selects write_data expected_read_data
// lines of one group start together, expected column is unused for writes
00 0 1 00000020 FFFF 00112233445566778899AABBCCDDEEFF 0
01 1 0 00000020 0000 0 00112233445566778899AABBCCDDEEFF
02 2 1 00000030 00FF 11111111111111112222222222222222 0
03 3 0 00000030 0000 0 5A03C3035A03C3022222222222222222
04 1 1 00000040 F00F DEADBEEF123456789ABCDEF0CAFEF00D 0
05 0 0 00000040 0000 0 DEADBEEF5A04C3025A04C301CAFEF00D
06 0 0 000000A0 0000 0 5A0AC3035A0AC3025A0AC3015A0AC300
06 1 0 000000B0 0000 0 5A0BC3035A0BC3025A0BC3015A0BC300
06 2 0 000000C0 0000 0 5A0CC3035A0CC3025A0CC3015A0CC300
06 3 0 000000D0 0000 0 5A0DC3035A0DC3025A0DC3015A0DC300
07 2 1 00000140 FFFF A1A2A3A4B1B2B3B4C1C2C3C4D1D2D3D4 0
07 3 1 00000150 0F0F 0123456789ABCDEFFEDCBA9876543210 0
08 0 0 00000140 0000 0 A1A2A3A4B1B2B3B4C1C2C3C4D1D2D3D4
08 1 0 00000150 0000 0 5A15C30389ABCDEF5A15C30176543210
09 1 1 00000140 FF00 EEEEEEEEEEEEEEEE1212121212121212 0
09 2 0 00000150 0000 0 5A15C30389ABCDEF5A15C30176543210
0A 3 0 00000140 0000 0 EEEEEEEEEEEEEEEEC1C2C3C4D1D2D3D4
0B 0 1 00000140 0001 11111111111111111111111111111177 0
0B 1 1 00000150 8000 99000000000000000000000000000000 0
0C 2 0 00000140 0000 0 EEEEEEEEEEEEEEEEC1C2C3C4D1D2D377
0C 3 0 00000150 0000 0 9915C30389ABCDEF5A15C30176543210
0C 0 0 00000020 0000 0 00112233445566778899AABBCCDDEEFF
0C 1 0 00000030 0000 0 5A03C3035A03C3022222222222222222

// ==== tb.f ====
+incdir+verilog
verilog/mpmc_pkg.sv
verilog/mpmc_req_arbiter.sv
verilog/mpmc_req_fifo.sv
verilog/mpmc_state_machine.sv
verilog/mpmc_resp_route.sv
verilog/mpmc_top.sv
testbench/app_mem_model.sv
testbench/tb_mpmc.sv

// ==== Bender.yml ====
package:
  name: mpmc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mpmc_pkg.sv
      - verilog/mpmc_req_arbiter.sv
      - verilog/mpmc_req_fifo.sv
      - verilog/mpmc_state_machine.sv
      - verilog/mpmc_resp_route.sv
      - verilog/mpmc_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/app_mem_model.sv
      - testbench/tb_mpmc.sv
